/* sim.f */
logic/cpu_pkg.sv
logic/instr_decode.sv
logic/cycle_fsm.sv
logic/exec_route.sv
logic/sequencer_top.sv
test/tb_sequencer.sv

/* run_sim.sh */
#!/bin/sh
# Builds the sequencer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sequencer \
	-f sim.f -o tb_sequencer_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_sequencer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
exit 1

/* test/seq_stim.txt */
// opcode p carry dl_sign stall_at  cycles alu_func abus_o p_mask bus_we route_cycle
// Cycles count from 0 at FETCH, stall_at 0 means no stall, route_cycle ignores the stall
20
69 00 00 00 00  02 02 02 E3 00 01  // ADC imm
E5 00 00 00 00  03 03 02 E3 00 02  // SBC zp
35 00 00 00 00  03 04 02 A2 00 02  // AND zp,X
0D 00 00 00 00  04 05 02 A2 00 03  // ORA abs
5D 00 00 00 00  04 06 02 A2 00 03  // EOR abs,X
BD 00 01 00 00  05 01 02 A2 00 04  // LDA abs,X page cross
C9 00 00 00 00  02 03 00 A3 00 01  // CMP imm
AE 00 00 00 00  04 01 04 A2 00 03  // LDX abs
85 00 00 00 00  03 00 01 20 01 02  // STA zp
8E 00 00 00 00  04 00 01 20 01 03  // STX abs
E6 00 00 00 00  04 02 01 A2 01 03  // INC zp
DE 00 01 00 00  06 03 01 A2 01 05  // DEC abs,X page cross
E8 00 00 00 00  02 02 04 A2 00 01  // INX
AA 00 00 00 00  02 00 04 A2 00 01  // TAX
8A 00 00 00 00  02 00 02 A2 00 01  // TXA
38 00 00 00 00  02 01 00 20 00 01  // SEC
18 01 00 00 00  02 01 00 20 00 01  // CLC
F0 00 00 00 00  02 01 00 20 00 01  // BEQ not taken
D0 00 00 00 00  03 02 40 20 00 01  // BNE taken
F0 02 01 01 00  03 03 00 20 00 02  // BEQ taken backward, same page
B0 01 01 00 00  04 02 80 20 00 02  // BCS taken, page fix-up
90 00 00 01 00  04 03 80 20 00 02  // BCC taken backward, page fix-up
4C 00 00 00 00  03 01 20 20 00 02  // JMP abs
48 00 00 00 00  03 00 01 20 01 01  // PHA
EA 00 00 00 00  02 01 00 20 00 01  // Unsupported opcode
69 00 00 00 01  02 02 02 E3 00 01  // ADC imm, stall in DECODE
F6 00 00 00 03  04 02 01 A2 01 03  // INC zp,X, stall in WRITE_BACK
BD 00 01 00 02  05 01 02 A2 00 04  // LDA abs,X, stall in READ_H
B0 01 01 00 02  04 02 80 20 00 02  // BCS fix-up, stall in BRANCH
38 00 00 00 01  02 01 00 20 00 01  // SEC, stall in DECODE
4C 00 00 00 02  03 01 20 20 00 02  // JMP, stall on PC load
48 00 00 00 01  03 00 01 20 01 01  // PHA, stall in DECODE

/* test/tb_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sequencer
	import cpu_pkg::*;
();

	localparam int FIELDS = 11;	// Values per stimulus line
	localparam int MAX_CASES = 40;
	localparam int MAX_CYCLES = 16;	// Longest legal instruction plus stall, with margin
	localparam byte_t OPC_SEC = 8'h38;
	localparam byte_t OPC_CLC = 8'h18;
	localparam byte_t OPC_PHA = 8'h48;
	localparam o_sel_t HOLD_BITS = o_sel_t'((8'd1 << O_SP) | (8'd1 << O_ADL)
		| (8'd1 << O_ADH) | (8'd1 << O_PCL) | (8'd1 << O_PCH));
	localparam status_t C_ONLY = status_t'(8'd1 << ST_C);

	logic sys;
	logic reset_i;
	byte_t opcode_i;
	status_t p_i;
	logic bus_rdy_i;
	logic dl_sign_i;
	logic alu_cout_i;
	logic fetch_o;
	logic bus_we_o;
	logic pc_addr_oe_o;
	logic ad_addr_oe_o;
	logic sp_addr_oe_o;
	logic pc_inc_o;
	logic pc_load_o;
	logic pcl_oe_o;
	alu_func_t alu_func_o;
	a_sel_t abus_a_o;
	b_sel_t abus_b_o;
	o_sel_t abus_o_o;
	logic alu_cinclr_o;
	status_t p_mask_o;
	status_t p_set_o;
	status_t p_clr_o;

	byte_t stim_mem [0:1 + FIELDS * MAX_CASES - 1];	// Word 0 is the case count
	integer seed = 32'hd5df8e8f;
	int case_no;

	sequencer_top UUT (.*);

	initial begin
		sys = 1'b0;
		forever #20 sys = ~sys;
	end

	task automatic halt_run();
		$display("Verification failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input int unsigned got,
		input int unsigned exp);
		$display("CHECK FAILED at %0t ns in case %0d: %s is %0h, expected %0h",
			$time, case_no, name, got, exp);
		halt_run();
	endtask

	task automatic bit_is(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic count_is(input string name, input int got, input int exp);
		if (got != exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic func_is(input string name, input alu_func_t got, input alu_func_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic route_is(input string name, input o_sel_t got, input o_sel_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic mask_is(input string name, input status_t got, input status_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic a_source_is(input string name, input a_sel_t got, input a_sel_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic b_source_is(input string name, input b_sel_t got, input b_sel_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	// Address source and data routing of a ready bus write
	task automatic check_write_cycle(input byte_t opc);
		bit rmw;
		a_sel_t exp_a;
		rmw = opc inside {8'hC6, 8'hD6, 8'hCE, 8'hDE, 8'hE6, 8'hF6, 8'hEE, 8'hFE};
		if (opc == OPC_PHA)
			bit_is("sp_addr_oe_o", sp_addr_oe_o, 1'b1);	// Push lands on the stack page
		else
			bit_is("ad_addr_oe_o", ad_addr_oe_o, 1'b1);
		if (rmw)
			exp_a = a_sel_t'(1) << A_DL;
		else if (opc inside {8'h86, 8'h8E})
			exp_a = a_sel_t'(1) << A_X;
		else
			exp_a = a_sel_t'(1) << A_ACC;
		a_source_is("abus_a_o", abus_a_o, exp_a);
		if (rmw) begin
			b_source_is("abus_b_o", abus_b_o, b_sel_t'(1) << B_CON);	// Constant one
			bit_is("alu_cinclr_o", alu_cinclr_o, 1'b1);
		end
	endtask

	// Entered at the falling edge of a FETCH cycle, left at the next one
	task automatic run_case(input int idx);
		int base;
		byte_t opc;
		int stall_at;
		int stall_len;
		int exp_len;
		int route_k;
		int decode_k;
		int k;
		int we_cnt;
		int set_cnt;
		int clr_cnt;
		logic carry;
		bit done;
		base = 1 + idx * FIELDS;
		opc = stim_mem[base];
		stall_at = stim_mem[base + 4];
		stall_len = 0;
		if (stall_at != 0)
			stall_len = 1 + ($unsigned($random(seed)) % 3);
		exp_len = stim_mem[base + 5] + stall_len;
		route_k = stim_mem[base + 10];
		if (stall_at != 0 && route_k >= stall_at)
			route_k = route_k + stall_len;	// Ready copy of the stalled state comes last
		decode_k = (stall_at == 1) ? 1 + stall_len : 1;	// Ready DECODE cycle
		k = 0;
		we_cnt = 0;
		set_cnt = 0;
		clr_cnt = 0;
		done = 1'b0;
		opcode_i = opc;
		p_i = stim_mem[base + 1];
		carry = stim_mem[base + 2][0];
		dl_sign_i = stim_mem[base + 3][0];
		while (!done) begin
			if (k > 0 && fetch_o) begin
				done = 1'b1;	// Next instruction has started
			end else if (k >= MAX_CYCLES) begin
				$display("Timeout: opcode %h did not return to fetch within %0d cycles",
					opc, MAX_CYCLES);
				halt_run();
			end else begin
				bus_rdy_i = !(stall_len != 0 && k >= stall_at && k < stall_at + stall_len);
				alu_cout_i = (k == decode_k) ? carry : ~carry;	// Other cycles carry the opposite
				#5;
				if (k == 0) begin
					bit_is("fetch_o", fetch_o, 1'b1);
					bit_is("pc_addr_oe_o", pc_addr_oe_o, 1'b1);
				end
				bit_is("p_mask_o[ST_R]", p_mask_o[ST_R], 1'b1);
				bit_is("pcl_oe_o", pcl_oe_o, 1'b0);	// No kept operation pushes the PC
				if (!bus_rdy_i) begin
					bit_is("pc_inc_o", pc_inc_o, 1'b0);
					bit_is("pc_load_o", pc_load_o, 1'b0);
					mask_is("p_set_o", p_set_o, '0);
					mask_is("p_clr_o", p_clr_o, '0);
					route_is("abus_o_o held bits", abus_o_o & HOLD_BITS, '0);
				end else begin
					if (bus_we_o) begin
						we_cnt++;
						check_write_cycle(opc);
					end
					if (p_set_o != '0) begin
						mask_is("p_set_o", p_set_o, C_ONLY);
						set_cnt++;
					end
					if (p_clr_o != '0) begin
						mask_is("p_clr_o", p_clr_o, C_ONLY);
						clr_cnt++;
					end
				end
				if (k == route_k) begin
					func_is("alu_func_o", alu_func_o, alu_func_t'(stim_mem[base + 6]));
					route_is("abus_o_o", abus_o_o, o_sel_t'(stim_mem[base + 7]));
					mask_is("p_mask_o", p_mask_o, status_t'(stim_mem[base + 8]));
				end
				@(negedge sys);
				k++;
			end
		end
		count_is("instruction cycles", k, exp_len);
		count_is("bus_we_o ready cycles", we_cnt, stim_mem[base + 9]);
		count_is("p_set_o[C] pulses", set_cnt, (opc == OPC_SEC) ? 1 : 0);
		count_is("p_clr_o[C] pulses", clr_cnt, (opc == OPC_CLC) ? 1 : 0);
	endtask

	initial begin
		int n;
		int i;
		reset_i = 1'b1;
		opcode_i = 8'hEA;
		p_i = '0;
		bus_rdy_i = 1'b1;
		dl_sign_i = 1'b0;
		alu_cout_i = 1'b0;
		case_no = 0;
		$readmemh("test/seq_stim.txt", stim_mem);
		n = stim_mem[0];
		if (n == 0 || n > MAX_CASES) begin
			$display("Stimulus file gives no usable case count (%0d)", n);
			halt_run();
		end

		repeat (2) @(negedge sys);
		#5;
		bit_is("fetch_o", fetch_o, 1'b1);	// FETCH while held in reset
		bit_is("pc_addr_oe_o", pc_addr_oe_o, 1'b1);
		bit_is("pc_inc_o", pc_inc_o, 1'b1);
		bit_is("bus_we_o", bus_we_o, 1'b0);
		bit_is("pc_load_o", pc_load_o, 1'b0);
		mask_is("p_set_o", p_set_o, '0);
		mask_is("p_clr_o", p_clr_o, '0);
		@(negedge sys);
		reset_i = 1'b0;	// Third rising edge has passed

		for (i = 0; i < n; i++) begin
			case_no = i + 1;
			run_case(i);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/sequencer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer_top
	import cpu_pkg::*;
(
	input wire sys,
	input wire reset_i,
	input wire byte_t opcode_i,
	input wire status_t p_i,
	input wire bus_rdy_i,
	input wire dl_sign_i,
	input wire alu_cout_i,
	output logic fetch_o,
	output logic bus_we_o,
	output logic pc_addr_oe_o,
	output logic ad_addr_oe_o,
	output logic sp_addr_oe_o,
	output logic pc_inc_o,
	output logic pc_load_o,
	output logic pcl_oe_o,
	output alu_func_t alu_func_o,
	output a_sel_t abus_a_o,
	output b_sel_t abus_b_o,
	output o_sel_t abus_o_o,
	output logic alu_cinclr_o,
	output status_t p_mask_o,
	output status_t p_set_o,
	output status_t p_clr_o
);

	op_t op;
	mode_t mode;
	logic branch_taken;
	logic exec;
	logic commit;	// Execute cycle that the bus accepts
	alu_func_t mu_func;
	a_sel_t mu_a;
	b_sel_t mu_b;
	o_sel_t mu_o;
	logic mu_cinclr;

	instr_decode u_decode (
		.opcode_i(opcode_i),
		.p_i(p_i),
		.op_o(op),
		.mode_o(mode),
		.branch_taken_o(branch_taken)
	);

	cycle_fsm u_fsm (
		.sys(sys),
		.reset_i(reset_i),
		.op_i(op),
		.mode_i(mode),
		.branch_taken_i(branch_taken),
		.bus_rdy_i(bus_rdy_i),
		.dl_sign_i(dl_sign_i),
		.alu_cout_i(alu_cout_i),
		.fetch_o(fetch_o),
		.bus_we_o(bus_we_o),
		.pc_addr_oe_o(pc_addr_oe_o),
		.ad_addr_oe_o(ad_addr_oe_o),
		.sp_addr_oe_o(sp_addr_oe_o),
		.pc_inc_o(pc_inc_o),
		.pc_load_o(pc_load_o),
		.pcl_oe_o(pcl_oe_o),
		.exec_o(exec),
		.commit_o(commit),
		.mu_func_o(mu_func),
		.mu_a_o(mu_a),
		.mu_b_o(mu_b),
		.mu_o_o(mu_o),
		.mu_cinclr_o(mu_cinclr)
	);

	exec_route u_route (
		.op_i(op),
		.mode_i(mode),
		.exec_i(exec),
		.commit_i(commit),
		.mu_func_i(mu_func),
		.mu_a_i(mu_a),
		.mu_b_i(mu_b),
		.mu_o_i(mu_o),
		.mu_cinclr_i(mu_cinclr),
		.alu_func_o(alu_func_o),
		.abus_a_o(abus_a_o),
		.abus_b_o(abus_b_o),
		.abus_o_o(abus_o_o),
		.alu_cinclr_o(alu_cinclr_o),
		.p_mask_o(p_mask_o),
		.p_set_o(p_set_o),
		.p_clr_o(p_clr_o)
	);

endmodule

`default_nettype wire

/* logic/exec_route.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_route
	import cpu_pkg::*;
(
	input wire op_t op_i,
	input wire mode_t mode_i,
	input wire exec_i,
	input wire commit_i,
	input wire alu_func_t mu_func_i,
	input wire a_sel_t mu_a_i,
	input wire b_sel_t mu_b_i,
	input wire o_sel_t mu_o_i,
	input wire mu_cinclr_i,
	output alu_func_t alu_func_o,
	output a_sel_t abus_a_o,
	output b_sel_t abus_b_o,
	output o_sel_t abus_o_o,
	output logic alu_cinclr_o,
	output status_t p_mask_o,
	output status_t p_set_o,
	output status_t p_clr_o
);

	localparam status_t MASK_R = status_t'(8'd1 << ST_R);
	localparam status_t MASK_NZ = status_t'((8'd1 << ST_N) | (8'd1 << ST_Z)) | MASK_R;
	localparam status_t MASK_NZC = MASK_NZ | status_t'(8'd1 << ST_C);
	localparam status_t MASK_NZCV = MASK_NZC | status_t'(8'd1 << ST_V);

	logic ex_valid;	// Operation has its own routing
	alu_func_t ex_func;
	a_sel_t ex_a;
	b_sel_t ex_b;
	o_sel_t ex_o;
	logic ex_cin;
	status_t ex_mask;

	always_comb begin
		ex_valid = 1'b1;
		ex_func = ALU_TXB;
		ex_a = a_src(A_CON);
		ex_b = b_src(B_BUS);
		ex_o = '0;
		ex_cin = 1'b0;
		ex_mask = MASK_R;
		case (op_i)
			OP_ADC, OP_SBC: begin
				ex_func = (op_i == OP_ADC) ? ALU_ADD : ALU_SUB;	// Carry in from P
				ex_a = a_src(A_ACC);
				ex_o = o_dst(O_ACC);
				ex_mask = MASK_NZCV;
			end
			OP_AND, OP_ORA, OP_EOR: begin
				ex_func = (op_i == OP_AND) ? ALU_AND : (op_i == OP_ORA) ? ALU_ORA : ALU_EOR;
				ex_a = a_src(A_ACC);
				ex_o = o_dst(O_ACC);
				ex_mask = MASK_NZ;
			end
			OP_CMP: begin
				ex_func = ALU_SUB;	// Flags only
				ex_a = a_src(A_ACC);
				ex_cin = 1'b1;
				ex_mask = MASK_NZC;
			end
			OP_LDA, OP_LDX, OP_LDY: begin
				ex_func = ALU_TXB;
				// Y has no route in this set, LDY only sets flags
				if (op_i == OP_LDA)
					ex_o = o_dst(O_ACC);
				else if (op_i == OP_LDX)
					ex_o = o_dst(O_X);
				ex_mask = MASK_NZ;
			end
			OP_TAX, OP_TXA: begin
				ex_func = ALU_TXA;
				ex_a = (op_i == OP_TAX) ? a_src(A_ACC) : a_src(A_X);
				ex_o = (op_i == OP_TAX) ? o_dst(O_X) : o_dst(O_ACC);
				ex_mask = MASK_NZ;
			end
			OP_INX, OP_DEX: begin
				ex_func = (op_i == OP_INX) ? ALU_ADD : ALU_SUB;	// X +/- 1
				ex_a = a_src(A_X);
				ex_b = b_src(B_CON);
				ex_o = o_dst(O_X);
				ex_cin = 1'b1;
				ex_mask = MASK_NZ;
			end
			OP_INC, OP_DEC: begin
				if (mode_i != MODE_IMP) begin
					ex_func = (op_i == OP_INC) ? ALU_ADD : ALU_SUB;	// DL +/- 1 back to memory
					ex_a = a_src(A_DL);
					ex_b = b_src(B_CON);
					ex_o = o_dst(O_BUS);
					ex_cin = 1'b1;
					ex_mask = MASK_NZ;
				end else begin
					ex_valid = 1'b0;
				end
			end
			OP_STA, OP_STX, OP_PHA: begin
				ex_func = ALU_TXA;	// Register onto data bus
				ex_a = (op_i == OP_STX) ? a_src(A_X) : a_src(A_ACC);
				ex_o = o_dst(O_BUS);
			end
			default: ex_valid = 1'b0;
		endcase
	end

	always_comb begin
		alu_func_o = (exec_i && ex_valid) ? ex_func : mu_func_i;
		abus_a_o = (exec_i && ex_valid) ? ex_a : mu_a_i;
		abus_b_o = (exec_i && ex_valid) ? ex_b : mu_b_i;
		abus_o_o = (exec_i && ex_valid) ? ex_o : mu_o_i;
		alu_cinclr_o = (exec_i && ex_valid) ? ex_cin : mu_cinclr_i;
		p_mask_o = exec_i ? ex_mask : MASK_R;
		p_set_o = '0;
		p_clr_o = '0;
		p_set_o[ST_C] = commit_i && (op_i == OP_SEC);
		p_clr_o[ST_C] = commit_i && (op_i == OP_CLC);
	end

	// Sequencer routes and operation routes must both keep the ALU sources exclusive
	always_comb begin
		a_src_onehot: assert ($onehot(abus_a_o)) else $error("ALU A source not one-hot");
		b_src_onehot: assert ($onehot(abus_b_o)) else $error("ALU B source not one-hot");
	end

endmodule

`default_nettype wire

/* logic/cycle_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_fsm
	import cpu_pkg::*;
(
	input wire sys,
	input wire reset_i,
	input wire op_t op_i,
	input wire mode_t mode_i,
	input wire branch_taken_i,
	input wire bus_rdy_i,
	input wire dl_sign_i,
	input wire alu_cout_i,
	output logic fetch_o,
	output logic bus_we_o,
	output logic pc_addr_oe_o,
	output logic ad_addr_oe_o,
	output logic sp_addr_oe_o,
	output logic pc_inc_o,
	output logic pc_load_o,
	output logic pcl_oe_o,
	output logic exec_o,
	output logic commit_o,
	output alu_func_t mu_func_o,
	output a_sel_t mu_a_o,
	output b_sel_t mu_b_o,
	output o_sel_t mu_o_o,
	output logic mu_cinclr_o
);

	// Destinations that commit register state and must not move on a stretched cycle
	localparam o_sel_t O_HOLD = o_sel_t'((8'd1 << O_SP) | (8'd1 << O_ADL) | (8'd1 << O_ADH)
		| (8'd1 << O_PCL) | (8'd1 << O_PCH));

	seq_state_t state;
	seq_state_t state_next;
	logic cout_prev;	// ALU carry of the last ready cycle
	logic pc_inc;
	logic pc_load;
	logic is_store;
	o_sel_t mu_o;

	always_ff @(posedge sys) begin
		if (reset_i) begin
			state <= FETCH;
			cout_prev <= 1'b0;
		end else if (bus_rdy_i) begin
			state <= state_next;
			cout_prev <= alu_cout_i;
		end
	end

	assign is_store = (op_i == OP_STA) || (op_i == OP_STX) || (op_i == OP_PHA);

	always_comb begin
		pc_addr_oe_o = 1'b0;
		ad_addr_oe_o = 1'b0;
		sp_addr_oe_o = 1'b0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		pcl_oe_o = 1'b0;	// No PC push in this instruction set
		exec_o = 1'b0;
		mu_func_o = ALU_TXB;
		mu_a_o = a_src(A_CON);
		mu_b_o = b_src(B_BUS);
		mu_o = '0;
		mu_cinclr_o = 1'b0;
		state_next = state;

		case (state)
			FETCH: begin
				pc_addr_oe_o = 1'b1;
				pc_inc = 1'b1;
				mu_func_o = ALU_TXA;	// Zero into ADH
				mu_o = o_dst(O_ADH);
				state_next = DECODE;
			end
			DECODE: begin
				pc_addr_oe_o = 1'b1;
				pc_inc = 1'b1;
				case (mode_i)
					MODE_IMP: begin
						pc_inc = 1'b0;
						exec_o = 1'b1;
						if (op_i == OP_PHA) begin
							pc_addr_oe_o = 1'b0;
							sp_addr_oe_o = 1'b1;	// Push ACC at SP
							state_next = PUSH;
						end else begin
							state_next = FETCH;
						end
					end
					MODE_IMM: begin
						exec_o = 1'b1;
						state_next = FETCH;
					end
					MODE_ZP, MODE_ABS: begin
						mu_func_o = ALU_TXB;	// Operand byte into ADL
						mu_o = o_dst(O_ADL);
						state_next = (mode_i == MODE_ZP) ? EXECUTE : READ_H;
					end
					MODE_ZPX, MODE_ABX: begin
						mu_func_o = ALU_ADD;	// X plus operand into ADL
						mu_a_o = a_src(A_X);
						mu_o = o_dst(O_ADL);
						mu_cinclr_o = 1'b1;
						state_next = (mode_i == MODE_ZPX) ? EXECUTE : READ_H;
					end
					MODE_REL: begin
						if (branch_taken_i) begin
							pc_inc = 1'b0;
							mu_func_o = ALU_ADD;	// PCL plus offset
							mu_a_o = a_src(A_PCL);
							mu_o = o_dst(O_PCL);
							mu_cinclr_o = 1'b1;
							state_next = BRANCH;
						end else begin
							state_next = FETCH;	// Offset skipped
						end
					end
					default: state_next = FETCH;
				endcase
			end
			READ_H: begin
				pc_addr_oe_o = 1'b1;
				mu_func_o = ALU_TXB;	// High byte into ADH
				mu_o = o_dst(O_ADH);
				if (op_i == OP_JMP) begin
					pc_load = 1'b1;
					state_next = FETCH;
				end else begin
					pc_inc = 1'b1;
					if (mode_i == MODE_ABX && cout_prev)
						state_next = READ_HP;	// Index crossed a page
					else
						state_next = EXECUTE;
				end
			end
			READ_HP: begin
				ad_addr_oe_o = 1'b1;
				mu_func_o = ALU_ADD;	// ADH plus one
				mu_a_o = a_src(A_ADH);
				mu_b_o = b_src(B_CON);
				mu_o = o_dst(O_ADH);
				mu_cinclr_o = 1'b1;
				state_next = EXECUTE;
			end
			EXECUTE: begin
				ad_addr_oe_o = 1'b1;
				if (op_i == OP_INC || op_i == OP_DEC) begin
					state_next = WRITE_BACK;	// Operand read only
				end else begin
					exec_o = 1'b1;
					state_next = FETCH;
				end
			end
			WRITE_BACK: begin
				ad_addr_oe_o = 1'b1;
				exec_o = 1'b1;
				state_next = FETCH;
			end
			BRANCH: begin
				pc_addr_oe_o = 1'b1;
				mu_func_o = dl_sign_i ? ALU_SUB : ALU_ADD;	// PCH moves with offset sign
				mu_a_o = a_src(A_PCH);
				mu_b_o = b_src(B_CON);
				mu_cinclr_o = 1'b1;
				if (cout_prev ^ dl_sign_i) begin
					mu_o = o_dst(O_PCH);
					state_next = BRANCH_OVF;
				end else begin
					pc_inc = 1'b1;
					state_next = FETCH;
				end
			end
			BRANCH_OVF: begin
				pc_addr_oe_o = 1'b1;
				pc_inc = 1'b1;
				state_next = FETCH;
			end
			PUSH: begin
				pc_addr_oe_o = 1'b1;
				mu_func_o = ALU_SUB;	// SP minus one
				mu_a_o = a_src(A_SP);
				mu_b_o = b_src(B_CON);
				mu_o = o_dst(O_SP);
				mu_cinclr_o = 1'b1;
				state_next = FETCH;
			end
			default: state_next = FETCH;
		endcase
	end

	assign fetch_o = (state == FETCH);
	assign bus_we_o = (state == WRITE_BACK) || (exec_o && is_store);
	assign commit_o = exec_o & bus_rdy_i;
	assign pc_inc_o = pc_inc & bus_rdy_i;
	assign pc_load_o = pc_load & bus_rdy_i;
	assign mu_o_o = bus_rdy_i ? mu_o : (mu_o & ~O_HOLD);

	// One source on the address bus per cycle
	a_addr_onehot: assert property (@(posedge sys) disable iff (reset_i)
		$onehot0({pc_addr_oe_o, ad_addr_oe_o, sp_addr_oe_o}));

endmodule

`default_nettype wire

/* logic/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
	import cpu_pkg::*;
(
	input wire byte_t opcode_i,
	input wire status_t p_i,
	output op_t op_o,
	output mode_t mode_o,
	output logic branch_taken_o
);

	op_t op;
	op_t grp_op;
	mode_t grp_mode;
	logic grp_ok;

	// Column 01 opcodes share an aaa/bbb layout
	always_comb begin
		case (opcode_i[7:5])
			3'd0: grp_op = OP_ORA;
			3'd1: grp_op = OP_AND;
			3'd2: grp_op = OP_EOR;
			3'd3: grp_op = OP_ADC;
			3'd4: grp_op = OP_STA;
			3'd5: grp_op = OP_LDA;
			3'd6: grp_op = OP_CMP;
			default: grp_op = OP_SBC;
		endcase
		case (opcode_i[4:2])
			3'b001: grp_mode = MODE_ZP;
			3'b010: grp_mode = MODE_IMM;
			3'b011: grp_mode = MODE_ABS;
			3'b101: grp_mode = MODE_ZPX;
			3'b111: grp_mode = MODE_ABX;
			default: grp_mode = MODE_IMP;	// Indirect and abs Y not built
		endcase
		grp_ok = (opcode_i[1:0] == 2'b01) && (grp_mode != MODE_IMP) && (opcode_i != 8'h89);
	end

	always_comb begin
		{op, mode_o} = {OP_NOP, MODE_IMP};
		if (grp_ok) begin
			{op, mode_o} = {grp_op, grp_mode};
		end else begin
			case (opcode_i)
				8'hA2: {op, mode_o} = {OP_LDX, MODE_IMM};
				8'hA6: {op, mode_o} = {OP_LDX, MODE_ZP};
				8'hAE: {op, mode_o} = {OP_LDX, MODE_ABS};
				8'hA0: {op, mode_o} = {OP_LDY, MODE_IMM};
				8'hA4: {op, mode_o} = {OP_LDY, MODE_ZP};
				8'hB4: {op, mode_o} = {OP_LDY, MODE_ZPX};
				8'hAC: {op, mode_o} = {OP_LDY, MODE_ABS};
				8'hBC: {op, mode_o} = {OP_LDY, MODE_ABX};
				8'h86: {op, mode_o} = {OP_STX, MODE_ZP};
				8'h8E: {op, mode_o} = {OP_STX, MODE_ABS};
				8'hE6: {op, mode_o} = {OP_INC, MODE_ZP};
				8'hF6: {op, mode_o} = {OP_INC, MODE_ZPX};
				8'hEE: {op, mode_o} = {OP_INC, MODE_ABS};
				8'hFE: {op, mode_o} = {OP_INC, MODE_ABX};
				8'hC6: {op, mode_o} = {OP_DEC, MODE_ZP};
				8'hD6: {op, mode_o} = {OP_DEC, MODE_ZPX};
				8'hCE: {op, mode_o} = {OP_DEC, MODE_ABS};
				8'hDE: {op, mode_o} = {OP_DEC, MODE_ABX};
				8'hE8: {op, mode_o} = {OP_INX, MODE_IMP};
				8'hCA: {op, mode_o} = {OP_DEX, MODE_IMP};
				8'hAA: {op, mode_o} = {OP_TAX, MODE_IMP};
				8'h8A: {op, mode_o} = {OP_TXA, MODE_IMP};
				8'h38: {op, mode_o} = {OP_SEC, MODE_IMP};
				8'h18: {op, mode_o} = {OP_CLC, MODE_IMP};
				8'hF0: {op, mode_o} = {OP_BEQ, MODE_REL};
				8'hD0: {op, mode_o} = {OP_BNE, MODE_REL};
				8'h90: {op, mode_o} = {OP_BCC, MODE_REL};
				8'hB0: {op, mode_o} = {OP_BCS, MODE_REL};
				8'h4C: {op, mode_o} = {OP_JMP, MODE_ABS};
				8'h48: {op, mode_o} = {OP_PHA, MODE_IMP};
				default: {op, mode_o} = {OP_NOP, MODE_IMP};
			endcase
		end
	end

	always_comb begin
		case (op)
			OP_BEQ: branch_taken_o = p_i[ST_Z];
			OP_BNE: branch_taken_o = ~p_i[ST_Z];
			OP_BCC: branch_taken_o = ~p_i[ST_C];
			OP_BCS: branch_taken_o = p_i[ST_C];
			default: branch_taken_o = 1'b0;
		endcase
	end

	assign op_o = op;

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [4:0] op_t;
	typedef logic [2:0] mode_t;
	typedef logic [2:0] alu_func_t;
	typedef logic [8:0] a_sel_t;
	typedef logic [2:0] b_sel_t;
	typedef logic [7:0] o_sel_t;
	typedef logic [7:0] status_t;

	localparam op_t OP_ADC = 5'd0;
	localparam op_t OP_SBC = 5'd1;
	localparam op_t OP_AND = 5'd2;
	localparam op_t OP_ORA = 5'd3;
	localparam op_t OP_EOR = 5'd4;
	localparam op_t OP_CMP = 5'd5;
	localparam op_t OP_LDA = 5'd6;
	localparam op_t OP_LDX = 5'd7;
	localparam op_t OP_LDY = 5'd8;
	localparam op_t OP_STA = 5'd9;
	localparam op_t OP_STX = 5'd10;
	localparam op_t OP_INC = 5'd11;
	localparam op_t OP_DEC = 5'd12;
	localparam op_t OP_INX = 5'd13;
	localparam op_t OP_DEX = 5'd14;
	localparam op_t OP_TAX = 5'd15;
	localparam op_t OP_TXA = 5'd16;
	localparam op_t OP_SEC = 5'd17;
	localparam op_t OP_CLC = 5'd18;
	localparam op_t OP_BEQ = 5'd19;
	localparam op_t OP_BNE = 5'd20;
	localparam op_t OP_BCC = 5'd21;
	localparam op_t OP_BCS = 5'd22;
	localparam op_t OP_JMP = 5'd23;
	localparam op_t OP_PHA = 5'd24;
	localparam op_t OP_NOP = 5'd31;	// Anything not decoded

	localparam mode_t MODE_IMP = 3'd0;	// Also accumulator
	localparam mode_t MODE_IMM = 3'd1;
	localparam mode_t MODE_ZP  = 3'd2;
	localparam mode_t MODE_ZPX = 3'd3;
	localparam mode_t MODE_ABS = 3'd4;
	localparam mode_t MODE_ABX = 3'd5;
	localparam mode_t MODE_REL = 3'd6;

	localparam alu_func_t ALU_TXA = 3'd0;	// Pass A side
	localparam alu_func_t ALU_TXB = 3'd1;	// Pass B side
	localparam alu_func_t ALU_ADD = 3'd2;
	localparam alu_func_t ALU_SUB = 3'd3;
	localparam alu_func_t ALU_AND = 3'd4;
	localparam alu_func_t ALU_ORA = 3'd5;
	localparam alu_func_t ALU_EOR = 3'd6;

	// ALU A-side sources, one-hot
	localparam int unsigned A_CON = 0;	// Constant zero
	localparam int unsigned A_ACC = 1;
	localparam int unsigned A_X   = 2;
	localparam int unsigned A_SP  = 3;
	localparam int unsigned A_DL  = 4;
	localparam int unsigned A_ADL = 5;
	localparam int unsigned A_PCL = 6;
	localparam int unsigned A_ADH = 7;	// Page fix-up of indexed address
	localparam int unsigned A_PCH = 8;	// Page fix-up of branch target

	localparam int unsigned B_BUS = 0;
	localparam int unsigned B_CON = 1;	// Constant one
	localparam int unsigned B_DL  = 2;

	localparam int unsigned O_BUS = 0;
	localparam int unsigned O_ACC = 1;
	localparam int unsigned O_X   = 2;
	localparam int unsigned O_SP  = 3;
	localparam int unsigned O_ADL = 4;
	localparam int unsigned O_ADH = 5;
	localparam int unsigned O_PCL = 6;
	localparam int unsigned O_PCH = 7;

	localparam int unsigned ST_C = 0;
	localparam int unsigned ST_Z = 1;
	localparam int unsigned ST_I = 2;
	localparam int unsigned ST_D = 3;
	localparam int unsigned ST_B = 4;
	localparam int unsigned ST_R = 5;	// Reserved, always written as one
	localparam int unsigned ST_V = 6;
	localparam int unsigned ST_N = 7;

	typedef enum logic [3:0] {
		FETCH, DECODE, EXECUTE, WRITE_BACK,
		READ_H, READ_HP, BRANCH, BRANCH_OVF, PUSH
	} seq_state_t;

	function automatic a_sel_t a_src(int unsigned idx);
		a_src = '0;
		a_src[idx] = 1'b1;
	endfunction

	function automatic b_sel_t b_src(int unsigned idx);
		b_src = '0;
		b_src[idx] = 1'b1;
	endfunction

	function automatic o_sel_t o_dst(int unsigned idx);
		o_dst = '0;
		o_dst[idx] = 1'b1;
	endfunction

endpackage

`default_nettype wire
